//--- hdl/burst_ingress.sv
`timescale 1ns/1ns

module burst_ingress (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         enable,
   pkt_cfg_if.ingress                   cfg,
   input  logic [pkt_pkg::sample_w-1:0] sample_data,
   input  logic                         sample_valid,
   output logic                         sample_ready,
   output logic [pkt_pkg::meta_w-1:0]   meta_data,
   output logic                         meta_valid,
   input  logic                         meta_space,
   output logic [pkt_pkg::word_w:0]     pair_data,
   output logic                         pair_valid,
   input  logic                         pair_space,
   output logic                         ingress_quiet
);

   enum logic {burst_new, burst_run} burst_state;
   enum logic [1:0] {in_idle, in_first, in_second} in_state;

   logic [pkt_pkg::burst_w-1:0]  burst_count;
   logic [pkt_pkg::burst_w-1:0]  burst_left;
   // 1-based index of the sample now at the input
   logic [pkt_pkg::size_w-1:0]   in_count;
   logic [pkt_pkg::time_w-1:0]   pkt_time;
   logic [pkt_pkg::time_w-1:0]   pkt_time_now;
   logic [pkt_pkg::sample_w-1:0] hold;
   logic                         beat;
   logic                         end_of_burst;
   logic                         end_of_packet;
   logic                         odd_tail;

   // Accept only with room in both buffers
   assign sample_ready = meta_space && pair_space && enable;
   assign beat         = sample_valid && sample_ready;

   // Samples left in the burst, counting the current one
   assign burst_left    = (burst_state == burst_new) ? cfg.burst_size : burst_count;
   assign end_of_burst  = !cfg.infinite_burst && (burst_left <= 1);
   // Short final packet when the burst runs out first
   assign end_of_packet = (in_count >= cfg.packet_size) || end_of_burst;
   // Odd sample count, last sample goes out alone
   assign odd_tail      = end_of_packet && in_count[0];

   // ----------------------------------------------------------------------
   // Burst tracking
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         burst_state <= burst_new;
         burst_count <= '0;
      end else if (!enable) begin
         burst_state <= burst_new;
      end else if (beat) begin
         burst_state <= end_of_burst ? burst_new : burst_run;
         // Wraps harmlessly in an endless burst
         burst_count <= burst_left - 1'b1;
      end
   end

   // ----------------------------------------------------------------------
   // Packet phase and sample pairing
   // ----------------------------------------------------------------------
   // Idle waits for a packet's first sample
   // Second half completes a pair, first half opens one
   always_ff @(posedge clk) begin
      if (rst || !enable) begin
         in_state <= in_idle;
         in_count <= 1;
      end else if (beat) begin
         if (end_of_packet) begin
            in_state <= in_idle;
            in_count <= 1;
         end else begin
            in_state <= (in_state == in_second) ? in_first : in_second;
            in_count <= in_count + 1'b1;
         end
      end
   end

   // Earlier sample of a pair
   always_ff @(posedge clk) begin
      if (beat) begin
         hold <= sample_data;
      end
   end

   // ----------------------------------------------------------------------
   // Packet time
   // ----------------------------------------------------------------------
   // Resolved at the first sample so a one-sample packet gets its own time
   always_comb begin
      if (in_state != in_idle) begin
         pkt_time_now = pkt_time;
      end else if (burst_state == burst_new) begin
         pkt_time_now = cfg.start_time;
      end else begin
         pkt_time_now = pkt_time
            + {{(pkt_pkg::time_w - pkt_pkg::incr_w){1'b0}}, cfg.time_per_pkt};
      end
   end

   always_ff @(posedge clk) begin
      if (beat) begin
         pkt_time <= pkt_time_now;
      end
   end

   // ----------------------------------------------------------------------
   // Buffer writes
   // ----------------------------------------------------------------------
   // One timestamp entry per packet, on its last sample
   assign meta_valid = beat && end_of_packet;
   assign meta_data  = {end_of_burst, in_count + pkt_pkg::header_words, pkt_time_now};

   // Pair word with packet-end flag on top
   assign pair_valid = beat && ((in_state == in_second) || odd_tail);
   assign pair_data  = {end_of_packet, odd_tail ? sample_data : hold, sample_data};

   // Between bursts with no packet open
   assign ingress_quiet = (burst_state == burst_new) && (in_state == in_idle);

endmodule

//--- hdl/drat_packetizer.sv
`timescale 1ns/1ns

module drat_packetizer (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         enable,
   input  logic [pkt_pkg::size_w-1:0]   packet_size,
   input  logic [pkt_pkg::burst_w-1:0]  burst_size,
   input  logic [pkt_pkg::incr_w-1:0]   time_per_pkt,
   input  logic [pkt_pkg::time_w-1:0]   start_time,
   input  logic [pkt_pkg::flow_w-1:0]   flow_id,
   input  logic [pkt_pkg::sample_w-1:0] sample_data,
   input  logic                         sample_valid,
   output logic                         sample_ready,
   output logic [pkt_pkg::word_w-1:0]   pkt_data,
   output logic                         pkt_valid,
   output logic                         pkt_last,
   input  logic                         pkt_ready,
   output logic                         idle
);

   // Ingress side of the buffers
   logic [pkt_pkg::meta_w-1:0] wr_meta;
   logic                       wr_meta_valid;
   logic                       meta_space;
   logic [pkt_pkg::word_w:0]   wr_pair;
   logic                       wr_pair_valid;
   logic                       pair_space;
   // Framer side of the buffers
   logic [pkt_pkg::meta_w-1:0] rd_meta;
   logic                       rd_meta_valid;
   logic                       meta_pop;
   logic [pkt_pkg::word_w:0]   rd_pair;
   logic                       rd_pair_valid;
   logic                       pair_pop;
   logic                       ingress_quiet;

   pkt_cfg_if cfg_bus ();

   pkt_config u_config (
      .clk(clk), .rst(rst), .enable(enable),
      .packet_size(packet_size), .burst_size(burst_size),
      .time_per_pkt(time_per_pkt), .start_time(start_time),
      .flow_id(flow_id), .cfg(cfg_bus.source)
   );

   burst_ingress u_ingress (
      .clk(clk), .rst(rst), .enable(enable), .cfg(cfg_bus.ingress),
      .sample_data(sample_data), .sample_valid(sample_valid),
      .sample_ready(sample_ready),
      .meta_data(wr_meta), .meta_valid(wr_meta_valid), .meta_space(meta_space),
      .pair_data(wr_pair), .pair_valid(wr_pair_valid), .pair_space(pair_space),
      .ingress_quiet(ingress_quiet)
   );

   // One entry per buffered packet
   stream_fifo #(.width(pkt_pkg::meta_w), .depth_log2(pkt_pkg::time_fifo_log2)) u_time_fifo (
      .clk(clk), .rst(rst),
      .in_data(wr_meta), .in_valid(wr_meta_valid), .in_ready(meta_space),
      .out_data(rd_meta), .out_valid(rd_meta_valid), .out_ready(meta_pop)
   );

   // Sample pairs with packet-end flag
   stream_fifo #(.width(pkt_pkg::word_w + 1), .depth_log2(pkt_pkg::sample_fifo_log2))
      u_sample_fifo (
      .clk(clk), .rst(rst),
      .in_data(wr_pair), .in_valid(wr_pair_valid), .in_ready(pair_space),
      .out_data(rd_pair), .out_valid(rd_pair_valid), .out_ready(pair_pop)
   );

   pkt_framer u_framer (
      .clk(clk), .rst(rst), .enable(enable), .cfg(cfg_bus.framer),
      .meta_data(rd_meta), .meta_valid(rd_meta_valid), .meta_pop(meta_pop),
      .pair_data(rd_pair), .pair_valid(rd_pair_valid), .pair_pop(pair_pop),
      .ingress_quiet(ingress_quiet),
      .pkt_data(pkt_data), .pkt_valid(pkt_valid), .pkt_last(pkt_last),
      .pkt_ready(pkt_ready), .idle(idle)
   );

endmodule

//--- hdl/pkt_cfg_if.sv
`timescale 1ns/1ns

interface pkt_cfg_if;

   // Frozen configuration, stable for the whole enable period
   logic [pkt_pkg::size_w-1:0]  packet_size;
   logic [pkt_pkg::burst_w-1:0] burst_size;
   logic [pkt_pkg::incr_w-1:0]  time_per_pkt;
   logic [pkt_pkg::time_w-1:0]  start_time;
   logic [pkt_pkg::flow_w-1:0]  flow_id;
   // Burst size of zero selects an endless burst
   logic                        infinite_burst;

   modport source (
      output packet_size, burst_size, time_per_pkt, start_time, flow_id, infinite_burst
   );

   // Ingress never needs the flow id
   modport ingress (
      input packet_size, burst_size, time_per_pkt, start_time, infinite_burst
   );

   modport framer (input flow_id);

endinterface

//--- hdl/pkt_config.sv
`timescale 1ns/1ns

module pkt_config (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        enable,
   input  logic [pkt_pkg::size_w-1:0]  packet_size,
   input  logic [pkt_pkg::burst_w-1:0] burst_size,
   input  logic [pkt_pkg::incr_w-1:0]  time_per_pkt,
   input  logic [pkt_pkg::time_w-1:0]  start_time,
   input  logic [pkt_pkg::flow_w-1:0]  flow_id,
   pkt_cfg_if.source                   cfg
);

   // ----------------------------------------------------------------------
   // Shadow registers
   // ----------------------------------------------------------------------
   // Track the inputs while disabled
   // Rising enable freezes the last loaded set
   always_ff @(posedge clk) begin
      if (rst) begin
         cfg.packet_size    <= '0;
         cfg.burst_size     <= '0;
         cfg.time_per_pkt   <= '0;
         cfg.start_time     <= '0;
         cfg.flow_id        <= '0;
         // Zero burst size after reset means endless
         cfg.infinite_burst <= 1'b1;
      end else if (!enable) begin
         cfg.packet_size    <= packet_size;
         cfg.burst_size     <= burst_size;
         cfg.time_per_pkt   <= time_per_pkt;
         cfg.start_time     <= start_time;
         cfg.flow_id        <= flow_id;
         // Decoded once here for all downstream users
         cfg.infinite_burst <= (burst_size == '0);
      end
   end

endmodule

//--- hdl/pkt_framer.sv
`timescale 1ns/1ns

module pkt_framer (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       enable,
   pkt_cfg_if.framer                  cfg,
   input  logic [pkt_pkg::meta_w-1:0] meta_data,
   input  logic                       meta_valid,
   output logic                       meta_pop,
   input  logic [pkt_pkg::word_w:0]   pair_data,
   input  logic                       pair_valid,
   output logic                       pair_pop,
   input  logic                       ingress_quiet,
   output logic [pkt_pkg::word_w-1:0] pkt_data,
   output logic                       pkt_valid,
   output logic                       pkt_last,
   input  logic                       pkt_ready,
   output logic                       idle
);

   enum logic [1:0] {st_header, st_time, st_samples, st_drain} state;

   logic [pkt_pkg::seq_w-1:0] seq_id;
   pkt_pkg::pkt_word_u        next_word;
   logic                      meta_eob;
   logic                      pair_last;
   logic                      load;
   logic                      emit;

   assign meta_eob  = meta_data[pkt_pkg::meta_w-1];
   assign pair_last = pair_data[pkt_pkg::word_w];

   // Output register may take a new word
   assign load = !pkt_valid || pkt_ready;

   // ----------------------------------------------------------------------
   // Word selection and FIFO pops
   // ----------------------------------------------------------------------
   always_comb begin
      emit     = 1'b0;
      meta_pop = 1'b0;
      pair_pop = 1'b0;
      // Time word by default
      next_word.raw = meta_data[pkt_pkg::time_w-1:0];
      case (state)
         st_header: begin
            emit = load && meta_valid;
            next_word.hdr.ptype = meta_eob ? pkt_pkg::pkt_type_eob : pkt_pkg::pkt_type_data;
            next_word.hdr.seq   = seq_id;
            next_word.hdr.size  = meta_data[pkt_pkg::time_w +: pkt_pkg::size_w];
            next_word.hdr.zero  = 2'b00;
            next_word.hdr.flow  = cfg.flow_id;
         end
         st_time: begin
            // Timestamp entry retires with the time word
            emit     = load && meta_valid;
            meta_pop = emit;
         end
         st_samples: begin
            emit     = load && pair_valid;
            pair_pop = emit;
            next_word.pair.early = pair_data[pkt_pkg::word_w-1 -: pkt_pkg::sample_w];
            next_word.pair.late  = pair_data[pkt_pkg::sample_w-1:0];
         end
         default: begin
            // Drain discards leftovers while disabled
            meta_pop = !enable;
            pair_pop = !enable;
         end
      endcase
   end

   // ----------------------------------------------------------------------
   // Output FSM
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_drain;
      end else begin
         case (state)
            st_header: begin
               if (emit) state <= st_time;
               else if (!meta_valid && !enable) state <= st_drain;
            end
            st_time: begin
               if (emit) state <= st_samples;
            end
            st_samples: begin
               if (emit && pair_last) state <= enable ? st_header : st_drain;
            end
            default: begin
               if (enable) state <= st_header;
            end
         endcase
      end
   end

   // Held word, only replaced once the previous one is taken
   always_ff @(posedge clk) begin
      if (rst) begin
         pkt_valid <= 1'b0;
         pkt_last  <= 1'b0;
      end else if (load) begin
         pkt_valid <= emit;
         pkt_last  <= emit && (state == st_samples) && pair_last;
      end
   end

   always_ff @(posedge clk) begin
      if (emit) begin
         pkt_data <= next_word.raw;
      end
   end

   // ----------------------------------------------------------------------
   // Sequence id and idle flag
   // ----------------------------------------------------------------------
   // Advances per header, restarts after an EOB header
   always_ff @(posedge clk) begin
      if (rst || !enable) begin
         seq_id <= '0;
      end else if ((state == st_header) && emit) begin
         seq_id <= meta_eob ? '0 : seq_id + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         idle <= 1'b1;
      end else begin
         idle <= !enable && ingress_quiet && !meta_valid && !pkt_valid;
      end
   end

endmodule

//--- hdl/pkt_pkg.sv
package pkt_pkg;

   // ----------------------------------------------------------------------
   // Stream and field widths
   // ----------------------------------------------------------------------
   // One complex sample, 16-bit I over 16-bit Q
   localparam int sample_w = 32;
   localparam int word_w   = 64;
   // Packet size and sample counters
   localparam int size_w   = 14;
   localparam int burst_w  = 48;
   localparam int time_w   = 64;
   localparam int flow_w   = 32;
   localparam int incr_w   = 16;
   localparam int seq_w    = 8;
   // Timestamp entry holds EOB flag, size and packet time
   localparam int meta_w   = 1 + size_w + time_w;

   // Buffer depths as powers of two
   localparam int time_fifo_log2   = 4;
   localparam int sample_fifo_log2 = 8;

   // Two header lines counted in 32-bit words
   localparam logic [size_w-1:0] header_words = 4;

   // Packet type codes
   localparam logic [7:0] pkt_type_data = 8'h10;
   localparam logic [7:0] pkt_type_eob  = 8'h11;

   // ----------------------------------------------------------------------
   // Output word, seen as header line or as sample pair
   // ----------------------------------------------------------------------
   typedef union packed {
      struct packed {
         logic [7:0]        ptype;
         logic [seq_w-1:0]  seq;
         logic [size_w-1:0] size;
         logic [1:0]        zero;
         logic [flow_w-1:0] flow;
      } hdr;
      struct packed {
         logic [sample_w-1:0] early;
         logic [sample_w-1:0] late;
      } pair;
      logic [word_w-1:0] raw;
   } pkt_word_u;

endpackage

//--- hdl/stream_fifo.sv
`timescale 1ns/1ns

module stream_fifo #(
   parameter int width      = 32,
   parameter int depth_log2 = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [width-1:0] in_data,
   input  logic             in_valid,
   output logic             in_ready,
   output logic [width-1:0] out_data,
   output logic             out_valid,
   input  logic             out_ready
);

   logic [width-1:0]    mem [2**depth_log2];
   logic [depth_log2-1:0] wr_ptr;
   logic [depth_log2-1:0] rd_ptr;
   // One extra bit so a full buffer can be told from an empty one
   logic [depth_log2:0]   count;
   logic                  push;
   logic                  pop;

   // Full when the top count bit is set
   assign in_ready  = !count[depth_log2];
   assign out_valid = (count != '0);
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;

   // First word falls through from the read pointer
   assign out_data = mem[rd_ptr];

   // ----------------------------------------------------------------------
   // Storage
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   // Pointers wrap naturally at the power-of-two depth
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the packetizer testbench with Verilator
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
   --top-module tb_packetizer --Mdir "$build_dir" -o tb_packetizer
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   echo "Checks failed"
   exit 1
fi

"./$build_dir/tb_packetizer" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   echo "Checks failed"
   exit 1
fi

if grep -q "All checks passed" "$log"; then
   exit 0
fi
echo "Checks failed"
exit 1

//--- testbench/packetizer_asserts.sv
`timescale 1ns/1ns

module packetizer_asserts (
   input logic                       clk,
   input logic                       rst,
   input logic [pkt_pkg::word_w-1:0] pkt_data,
   input logic                       pkt_valid,
   input logic                       pkt_last,
   input logic                       pkt_ready,
   input logic                       idle
);

   // Next word opens a packet
   logic at_head;

   always_ff @(posedge clk) begin
      if (rst) begin
         at_head <= 1'b1;
      end else if (pkt_valid && pkt_ready) begin
         at_head <= pkt_last;
      end
   end

   // ---------------------------------------------------------------------
   // Output stream handshake
   // ---------------------------------------------------------------------
   // Stalled word and last flag stay put
   held_on_stall: assert property (@(posedge clk) disable iff (rst)
      pkt_valid && !pkt_ready |=> pkt_valid && $stable(pkt_data) && $stable(pkt_last))
      else $error("pkt_data or pkt_last changed under back-pressure");

   // Every packet starts with a header line
   header_first: assert property (@(posedge clk) disable iff (rst)
      pkt_valid && at_head |->
         (pkt_data[63:56] == pkt_pkg::pkt_type_data
            || pkt_data[63:56] == pkt_pkg::pkt_type_eob)
         && pkt_data[33:32] == 2'b00)
      else $error("packet does not open with a header line");

   // Idle never overlaps an output word
   idle_quiet: assert property (@(posedge clk) disable iff (rst) idle |-> !pkt_valid)
      else $error("idle high while pkt_valid");

endmodule

bind drat_packetizer packetizer_asserts u_asserts (
   .clk(clk), .rst(rst),
   .pkt_data(pkt_data), .pkt_valid(pkt_valid), .pkt_last(pkt_last),
   .pkt_ready(pkt_ready), .idle(idle)
);

//--- testbench/tb_packetizer.sv
`timescale 1ns/1ns

module tb_packetizer;

   localparam int n_rows = 7;
   // Case table, one column per array
   // Packet size, burst size (0 is endless), time step, start time, flow id,
   // sample count and share of cycles in percent with pkt_ready low
   localparam int          psize_tab [n_rows] = '{8, 5, 6, 3, 1, 16, 1};
   localparam int          bsize_tab [n_rows] = '{0, 12, 0, 7, 3, 40, 0};
   localparam int          incr_tab  [n_rows] = '{100, 37, 250, 9, 1, 1000, 3};
   localparam logic [63:0] start_tab [n_rows] = '{64'h1000, 64'hff_ffff_fff0,
      64'h1234_5678_0000_0000, 64'hffff_ffff_ffff_ff00, 64'h0, 64'h1_0000_0000, 64'h8000_0000};
   localparam logic [31:0] flow_tab  [n_rows] = '{32'ha5a5_0001, 32'h0000_beef, 32'h0bad_cafe,
      32'h7777_0003, 32'h1, 32'hdead_0005, 32'h0f0f};
   localparam int          count_tab [n_rows] = '{32, 36, 42, 21, 6, 80, 300};
   localparam int          stall_tab [n_rows] = '{0, 0, 40, 30, 20, 25, 10};

   logic                         clk;
   logic                         rst;
   logic                         enable;
   logic [pkt_pkg::size_w-1:0]   packet_size;
   logic [pkt_pkg::burst_w-1:0]  burst_size;
   logic [pkt_pkg::incr_w-1:0]   time_per_pkt;
   logic [pkt_pkg::time_w-1:0]   start_time;
   logic [pkt_pkg::flow_w-1:0]   flow_id;
   logic [pkt_pkg::sample_w-1:0] sample_data;
   logic                         sample_valid;
   logic                         sample_ready;
   logic [pkt_pkg::word_w-1:0]   pkt_data;
   logic                         pkt_valid;
   logic                         pkt_last;
   logic                         pkt_ready;
   logic                         idle;

   integer      seed;
   int          stall_draw [1024];
   int          stall_pct;
   int          cycles;
   int          cycle_limit;
   int          errors;
   int          checks;
   // Words kept as {last, data}
   logic [31:0] samples [$];
   logic [64:0] expect_q [$];
   logic [64:0] got_q [$];

   drat_packetizer u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ---------------------------------------------------------------------
   // Output side: back-pressure pattern and word capture
   // ---------------------------------------------------------------------
   initial begin
      int idx;
      idx = 0;
      pkt_ready = 1'b1;
      forever begin
         @(posedge clk);
         #1;
         pkt_ready = (stall_draw[idx] >= stall_pct);
         idx = (idx + 1) % 1024;
      end
   end

   always @(posedge clk) begin
      if (pkt_valid && pkt_ready) got_q.push_back({pkt_last, pkt_data});
   end

   // Budget of 10 cycles per sample plus 300 per row
   initial begin
      cycle_limit = 0;
      for (int r = 0; r < n_rows; r++) cycle_limit += 10 * count_tab[r] + 300;
      cycles = 0;
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, the packetizer stopped making progress", cycles);
      $display("Checks failed");
      $finish;
   end

   // ---------------------------------------------------------------------
   // Main sequence
   // ---------------------------------------------------------------------
   initial begin
      int          k;
      int          n;
      int          done;
      int          pos;
      int          base;
      logic [7:0]  seq;
      logic [63:0] t;
      logic [31:0] late;
      logic        eob;
      logic        last;
      seed = 32'h2e7e_b08e;
      errors = 0;
      checks = 0;
      stall_pct = 0;
      for (k = 0; k < 1024; k++) stall_draw[k] = $unsigned($random(seed)) % 100;
      rst = 1'b1;
      enable = 1'b0;
      packet_size = '0;
      burst_size = '0;
      time_per_pkt = '0;
      start_time = '0;
      flow_id = '0;
      sample_data = '0;
      sample_valid = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      @(posedge clk);
      if (idle !== 1'b1 || pkt_valid !== 1'b0 || sample_ready !== 1'b0) begin
         $display("Fail after reset idle %h pkt_valid %h sample_ready %h",
            idle, pkt_valid, sample_ready);
         errors++;
      end
      $display("After reset: %0d errors", errors);
      #1;
      for (int r = 0; r < n_rows; r++) begin
         base = errors;
         samples.delete();
         for (k = 0; k < count_tab[r]; k++) samples.push_back($random(seed));
         // Expected words straight from the packet content rule
         expect_q.delete();
         done = 0;
         pos = 0;
         seq = 8'h00;
         t = start_tab[r];
         while (done < count_tab[r]) begin
            n = psize_tab[r];
            if (bsize_tab[r] != 0 && bsize_tab[r] - pos < n) n = bsize_tab[r] - pos;
            eob = (bsize_tab[r] != 0) && (pos + n == bsize_tab[r]);
            expect_q.push_back({1'b0, eob ? 8'h11 : 8'h10, seq, 14'(n + 4), 2'b00, flow_tab[r]});
            expect_q.push_back({1'b0, t});
            for (k = 0; k < n; k += 2) begin
               // Odd tail repeats its own sample
               late = (k + 1 < n) ? samples[done + k + 1] : samples[done + k];
               last = (k + 2 >= n);
               expect_q.push_back({last, samples[done + k], late});
            end
            done += n;
            seq = eob ? 8'h00 : seq + 8'h01;
            pos = eob ? 0 : pos + n;
            t = eob ? start_tab[r] : t + 64'(incr_tab[r]);
         end
         got_q.delete();
         stall_pct = stall_tab[r];
         packet_size = 14'(psize_tab[r]);
         burst_size = 48'(bsize_tab[r]);
         time_per_pkt = 16'(incr_tab[r]);
         start_time = start_tab[r];
         flow_id = flow_tab[r];
         repeat (2) @(posedge clk);
         #1;
         enable = 1'b1;
         // New inputs while enabled must not reach this run
         packet_size = 14'($random(seed));
         burst_size = {$random(seed), 16'h0001};
         time_per_pkt = 16'($random(seed));
         start_time = {$random(seed), $random(seed)};
         flow_id = $random(seed);
         k = 0;
         while (k < count_tab[r]) begin
            sample_data = samples[k];
            sample_valid = 1'b1;
            @(posedge clk);
            if (sample_ready) k++;
            #1;
         end
         sample_valid = 1'b0;
         while (got_q.size() < expect_q.size()) @(posedge clk);
         #1;
         enable = 1'b0;
         do @(posedge clk); while (idle !== 1'b1);
         #1;
         if (got_q.size() != expect_q.size()) begin
            $display("Row %0d gave %0d words but %0d were expected",
               r, got_q.size(), expect_q.size());
            errors++;
         end
         for (k = 0; k < got_q.size() && k < expect_q.size(); k++) begin
            checks++;
            if (got_q[k][63:0] !== expect_q[k][63:0]) begin
               $display("Fail row %0d word %0d pkt_data got %h expected %h",
                  r, k, got_q[k][63:0], expect_q[k][63:0]);
               errors++;
            end
            if (got_q[k][64] !== expect_q[k][64]) begin
               $display("Fail row %0d word %0d pkt_last got %h expected %h",
                  r, k, got_q[k][64], expect_q[k][64]);
               errors++;
            end
         end
         $display("Row %0d: %0d samples, %0d words, %0d errors",
            r, count_tab[r], got_q.size(), errors - base);
      end
      $display("%0d rows, %0d words checked, %0d errors", n_rows, checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- vlog.f
hdl/pkt_pkg.sv
hdl/pkt_cfg_if.sv
hdl/pkt_config.sv
hdl/stream_fifo.sv
hdl/burst_ingress.sv
hdl/pkt_framer.sv
hdl/drat_packetizer.sv
testbench/packetizer_asserts.sv
testbench/tb_packetizer.sv
